/* rtl/stack_cfg.svh */
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

// datapath geometry.
`define STACK_DATA_WIDTH 64
`define STACK_KEEP_WIDTH 8

// udp ports.
`define ROCE_UDP_PORT  16'h12B7
`define CM_LISTEN_PORT 16'h4321 // control frames land here.

// bth constants for the single packet write.
`define ROCE_OP_RDMA_WRITE_ONLY 8'h0A
`define ROCE_P_KEY              16'hFFFF

// udp 8 + bth 12 + reth 16.
`define ROCE_HDR_BYTES 36

`define CM_FRAME_WORDS 3 // len/qpn, psn/rkey, vaddr.

`endif

/* rtl/net_pkg.sv */
`include "stack_cfg.svh"

package net_pkg;

  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;

  typedef logic [`STACK_DATA_WIDTH-1:0] axis_data_t;
  typedef logic [`STACK_KEEP_WIDTH-1:0] axis_keep_t;

  // one stream beat.
  typedef struct packed {
    axis_data_t data;
    axis_keep_t keep;
    logic       last;
  } axis_beat_t;

  // received udp/ip header, mac and checksum fields stay below.
  typedef struct packed {
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;
  } udp_rx_hdr_t;

endpackage

/* rtl/roce_pkg.sv */
package roce_pkg;

  import net_pkg::*;

  typedef logic [23:0] qpn_t;
  typedef logic [23:0] psn_t;
  typedef logic [31:0] rkey_t;
  typedef logic [63:0] vaddr_t;
  typedef logic [31:0] dma_len_t;

  typedef struct packed {
    ip_addr_t rem_ip;
    qpn_t     qpn;
    psn_t     psn;
    rkey_t    r_key;
    vaddr_t   vaddr;
    dma_len_t dma_len;
  } xfer_params_t;

  // udp/ip part first, then bth and reth.
  typedef struct packed {
    ip_addr_t    src_ip;
    ip_addr_t    dst_ip;
    udp_port_t   src_port;
    udp_port_t   dst_port;
    udp_len_t    udp_len;
    logic [7:0]  opcode;
    logic [15:0] p_key;
    psn_t        psn;
    qpn_t        dest_qp;
    logic        ack_req;
    vaddr_t      vaddr;
    rkey_t       r_key;
    dma_len_t    dma_len;
  } roce_tx_hdr_t;

  typedef enum logic [1:0] {steer_idle, steer_to_cm, steer_drop} steer_state_t;

  typedef enum logic [1:0] {framer_idle, framer_header, framer_payload} framer_state_t;

endpackage

/* rtl/udp_rx_steer.sv */
`timescale 1ns/1ps
`include "stack_cfg.svh"

module udp_rx_steer
  import net_pkg::*;
  import roce_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  udp_rx_hdr_t rx_hdr,
  input  logic        rx_hdr_valid,
  output logic        rx_hdr_ready,
  input  axis_beat_t  rx_beat,
  input  logic        rx_valid,
  output logic        rx_ready,
  output udp_rx_hdr_t cm_hdr,
  output logic        cm_hdr_valid,
  input  logic        cm_hdr_ready,
  output axis_beat_t  cm_beat,
  output logic        cm_valid,
  input  logic        cm_ready
);

  steer_state_t state;
  logic         is_cm;
  logic         hdr_fire;
  logic         beat_fire;

  assign is_cm = (rx_hdr.dst_port == `CM_LISTEN_PORT);

  assign cm_hdr       = rx_hdr;
  assign cm_hdr_valid = (state == steer_idle) && rx_hdr_valid && is_cm;
  assign rx_hdr_ready = (state == steer_idle) && (is_cm ? cm_hdr_ready : 1'b1);

  assign cm_beat  = rx_beat;
  assign cm_valid = (state == steer_to_cm) && rx_valid;

  always_comb begin
    case (state)
      steer_to_cm: rx_ready = cm_ready;
      steer_drop:  rx_ready = 1'b1; // drop sink never stalls.
      default:     rx_ready = 1'b0;
    endcase
  end

  assign hdr_fire  = rx_hdr_valid && rx_hdr_ready;
  assign beat_fire = rx_valid && rx_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= steer_idle;
    end else begin
      case (state)
        steer_idle: begin
          if (hdr_fire) begin
            if (is_cm) begin
              state <= steer_to_cm;
            end else begin
              state <= steer_drop;
            end
          end
        end
        default: begin
          // frame ends on the accepted last beat.
          if (beat_fire && rx_beat.last) begin
            state <= steer_idle;
          end
        end
      endcase
    end
  end

endmodule

/* rtl/conn_manager.sv */
`timescale 1ns/1ps
`include "stack_cfg.svh"

module conn_manager
  import net_pkg::*;
  import roce_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  udp_rx_hdr_t  cm_hdr,
  input  logic         cm_hdr_valid,
  output logic         cm_hdr_ready,
  input  axis_beat_t   cm_beat,
  input  logic         cm_valid,
  output logic         cm_ready,
  output xfer_params_t params,
  output logic         start
);

  localparam int CNT_W = $clog2(`CM_FRAME_WORDS + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`CM_FRAME_WORDS);
  localparam logic [CNT_W-1:0] CNT_LAST_MIN = CNT_W'(`CM_FRAME_WORDS - 1);

  logic             in_body;
  logic [CNT_W-1:0] beat_cnt;
  xfer_params_t     stage;
  xfer_params_t     stage_next;
  logic             hdr_fire;
  logic             beat_fire;
  logic             commit;

  assign cm_hdr_ready = !in_body;
  assign cm_ready     = in_body;

  assign hdr_fire  = cm_hdr_valid && cm_hdr_ready;
  assign beat_fire = cm_valid && cm_ready;
  assign commit    = beat_fire && cm_beat.last && (beat_cnt >= CNT_LAST_MIN);

  // fold the current word into the staged fields.
  always_comb begin
    stage_next = stage;
    case (beat_cnt)
      CNT_W'(0): begin
        stage_next.dma_len = cm_beat.data[31:0];
        stage_next.qpn     = cm_beat.data[55:32];
      end
      CNT_W'(1): begin
        stage_next.psn   = cm_beat.data[23:0];
        stage_next.r_key = cm_beat.data[63:32];
      end
      CNT_W'(2): stage_next.vaddr = cm_beat.data;
      default: stage_next = stage; // extra words ignored.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_body  <= 1'b0;
      beat_cnt <= '0;
      start    <= 1'b0;
    end else begin
      start <= commit;
      if (hdr_fire) begin
        in_body  <= 1'b1;
        beat_cnt <= '0;
      end
      if (beat_fire) begin
        if (beat_cnt != CNT_MAX) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        if (cm_beat.last) begin
          in_body <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      stage.rem_ip <= cm_hdr.src_ip; // reply goes back to the sender.
    end else if (beat_fire) begin
      stage <= stage_next;
    end
    if (commit) begin
      params <= stage_next;
    end
  end

endmodule

/* rtl/payload_gen.sv */
`timescale 1ns/1ps
`include "stack_cfg.svh"

module payload_gen
  import net_pkg::*;
  import roce_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       gen_start,
  input  dma_len_t   length,
  output axis_beat_t gen_beat,
  output logic       gen_valid,
  input  logic       gen_ready
);

  localparam int BEAT_BYTES = `STACK_KEEP_WIDTH;
  localparam int TAIL_W = $clog2(BEAT_BYTES);

  dma_len_t          cnt;
  dma_len_t          len_q;
  logic [32:0]       cnt_step; // one spare bit against wrap.
  logic [TAIL_W-1:0] tail;
  axis_keep_t        tail_keep;
  logic              is_last;

  assign cnt_step  = {1'b0, cnt} + 33'(BEAT_BYTES);
  assign tail      = len_q[TAIL_W-1:0];
  assign tail_keep = (tail == '0) ? '1 : ~(axis_keep_t'('1) << tail);
  assign is_last   = (cnt_step >= {1'b0, len_q});

  assign gen_valid = (cnt < len_q);

  // counter low, inverse high.
  always_comb begin
    gen_beat.data = {~cnt, cnt};
    gen_beat.keep = is_last ? tail_keep : '1;
    gen_beat.last = is_last;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      len_q <= '0;
    end else if (gen_start) begin
      cnt   <= '0;
      len_q <= length;
    end else if (gen_valid && gen_ready) begin
      // park on the length once the last beat is taken.
      if (is_last) begin
        cnt <= len_q;
      end else begin
        cnt <= cnt_step[31:0];
      end
    end
  end

endmodule

/* rtl/roce_tx_framer.sv */
`timescale 1ns/1ps
`include "stack_cfg.svh"

module roce_tx_framer
  import net_pkg::*;
  import roce_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  xfer_params_t params,
  input  logic         start,
  input  ip_addr_t     loc_ip_addr,
  output roce_tx_hdr_t tx_hdr,
  output logic         tx_hdr_valid,
  input  logic         tx_hdr_ready,
  output logic         gen_start,
  output dma_len_t     length,
  input  axis_beat_t   gen_beat,
  input  logic         gen_valid,
  output logic         gen_ready,
  output axis_beat_t   tx_beat,
  output logic         tx_valid,
  input  logic         tx_ready,
  output logic         busy
);

  framer_state_t state;
  roce_tx_hdr_t  hdr_q;
  logic          hdr_fire;
  logic          last_fire;

  assign hdr_fire  = tx_hdr_valid && tx_hdr_ready;
  assign last_fire = tx_valid && tx_ready && gen_beat.last;

  assign tx_hdr       = hdr_q;
  assign tx_hdr_valid = (state == framer_header);
  assign busy         = (state != framer_idle);

  assign gen_start = hdr_fire; // first beat one cycle later.
  assign length    = hdr_q.dma_len;

  // beats pass straight through, tx_ready stalls the generator.
  assign tx_beat   = gen_beat;
  assign tx_valid  = (state == framer_payload) && gen_valid;
  assign gen_ready = (state == framer_payload) && tx_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= framer_idle;
    end else begin
      case (state)
        framer_idle: begin
          if (start) begin
            state <= framer_header; // start seen only here.
          end
        end
        framer_header: begin
          if (hdr_fire) begin
            if (hdr_q.dma_len == '0) begin
              state <= framer_idle;
            end else begin
              state <= framer_payload;
            end
          end
        end
        framer_payload: begin
          if (last_fire) begin
            state <= framer_idle;
          end
        end
        default: state <= framer_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == framer_idle) && start) begin
      hdr_q.src_ip   <= loc_ip_addr;
      hdr_q.dst_ip   <= params.rem_ip;
      hdr_q.src_port <= `ROCE_UDP_PORT;
      hdr_q.dst_port <= `ROCE_UDP_PORT;
      hdr_q.udp_len  <= udp_len_t'(`ROCE_HDR_BYTES) + params.dma_len[15:0];
      hdr_q.opcode   <= `ROCE_OP_RDMA_WRITE_ONLY;
      hdr_q.p_key    <= `ROCE_P_KEY;
      hdr_q.psn      <= params.psn;
      hdr_q.dest_qp  <= params.qpn;
      hdr_q.ack_req  <= 1'b1;
      hdr_q.vaddr    <= params.vaddr;
      hdr_q.r_key    <= params.r_key;
      hdr_q.dma_len  <= params.dma_len;
    end
  end

endmodule

/* rtl/roce_min_stack.sv */
`timescale 1ns/1ps

module roce_min_stack
  import net_pkg::*;
  import roce_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  ip_addr_t     loc_ip_addr,
  input  udp_rx_hdr_t  rx_hdr,
  input  logic         rx_hdr_valid,
  output logic         rx_hdr_ready,
  input  axis_beat_t   rx_beat,
  input  logic         rx_valid,
  output logic         rx_ready,
  output roce_tx_hdr_t tx_hdr,
  output logic         tx_hdr_valid,
  input  logic         tx_hdr_ready,
  output axis_beat_t   tx_beat,
  output logic         tx_valid,
  input  logic         tx_ready,
  output logic         busy
);

  udp_rx_hdr_t  cm_hdr;
  logic         cm_hdr_valid;
  logic         cm_hdr_ready;
  axis_beat_t   cm_beat;
  logic         cm_valid;
  logic         cm_ready;
  xfer_params_t params;
  logic         start;
  logic         gen_start;
  dma_len_t     length;
  axis_beat_t   gen_beat;
  logic         gen_valid;
  logic         gen_ready;

  udp_rx_steer i_udp_rx_steer (
    .clk          (clk),
    .rst          (rst),
    .rx_hdr       (rx_hdr),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_hdr_ready (rx_hdr_ready),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .cm_hdr       (cm_hdr),
    .cm_hdr_valid (cm_hdr_valid),
    .cm_hdr_ready (cm_hdr_ready),
    .cm_beat      (cm_beat),
    .cm_valid     (cm_valid),
    .cm_ready     (cm_ready)
  );

  conn_manager i_conn_manager (
    .clk          (clk),
    .rst          (rst),
    .cm_hdr       (cm_hdr),
    .cm_hdr_valid (cm_hdr_valid),
    .cm_hdr_ready (cm_hdr_ready),
    .cm_beat      (cm_beat),
    .cm_valid     (cm_valid),
    .cm_ready     (cm_ready),
    .params       (params),
    .start        (start)
  );

  payload_gen i_payload_gen (
    .clk       (clk),
    .rst       (rst),
    .gen_start (gen_start),
    .length    (length),
    .gen_beat  (gen_beat),
    .gen_valid (gen_valid),
    .gen_ready (gen_ready)
  );

  roce_tx_framer i_roce_tx_framer (
    .clk          (clk),
    .rst          (rst),
    .params       (params),
    .start        (start),
    .loc_ip_addr  (loc_ip_addr),
    .tx_hdr       (tx_hdr),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready),
    .gen_start    (gen_start),
    .length       (length),
    .gen_beat     (gen_beat),
    .gen_valid    (gen_valid),
    .gen_ready    (gen_ready),
    .tx_beat      (tx_beat),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .busy         (busy)
  );

endmodule

/* tests/tb_roce_min_stack.sv */
`timescale 1ns/1ps
`include "stack_cfg.svh"

module tb_roce_min_stack
  import net_pkg::*;
  import roce_pkg::*;
();

  localparam ip_addr_t LOC_IP = 32'hC0A8_0A01;
  // 8 transfers of up to 64 beats under back-pressure, plus side frames.
  localparam int MAX_CYCLES = 8 * (64 * 4 + 40) + 500;

  logic         clk;
  logic         rst;
  ip_addr_t     loc_ip_addr;
  udp_rx_hdr_t  rx_hdr;
  logic         rx_hdr_valid;
  logic         rx_hdr_ready;
  axis_beat_t   rx_beat;
  logic         rx_valid;
  logic         rx_ready;
  roce_tx_hdr_t tx_hdr;
  logic         tx_hdr_valid;
  logic         tx_hdr_ready;
  axis_beat_t   tx_beat;
  logic         tx_valid;
  logic         tx_ready;
  logic         busy;

  logic [63:0]  fw [0:7]; // payload words of the next rx frame.
  roce_tx_hdr_t exp_hdr;
  axis_beat_t   exp_beat;
  logic         drop_expect;
  int           hdr_sent;
  int           beats_exp;
  int           hdr_seen;
  int           beat_idx;
  int           beat_total;
  int           cycles = 0;

  roce_min_stack i_roce_min_stack (
    .clk          (clk),
    .rst          (rst),
    .loc_ip_addr  (loc_ip_addr),
    .rx_hdr       (rx_hdr),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_hdr_ready (rx_hdr_ready),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .tx_hdr       (tx_hdr),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready),
    .tx_beat      (tx_beat),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .busy         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Test failures found");
      $fatal(1, "run timed out after %0d cycles", cycles);
    end
  end

  // expected beat from byte offset idx*8 and the transfer length.
  function automatic axis_beat_t model_beat(input dma_len_t len, input int idx);
    axis_beat_t  b;
    logic [31:0] off;
    int          nbeats;
    int          rem;
    off = idx * 8;
    nbeats = int'((len + 32'd7) / 32'd8);
    b.data = {~off, off};
    b.last = (idx == nbeats - 1);
    b.keep = '1;
    if (b.last) begin
      rem = int'(len - off); // 1 to 8 bytes left.
      for (int k = 0; k < `STACK_KEEP_WIDTH; k++) begin
        b.keep[k] = (k < rem);
      end
    end
    return b;
  endfunction

  always_comb exp_beat = model_beat(exp_hdr.dma_len, beat_idx);

  always @(posedge clk) begin
    if (rst) begin
      hdr_seen   <= 0;
      beat_idx   <= 0;
      beat_total <= 0;
    end else begin
      if (tx_hdr_valid && tx_hdr_ready) begin
        hdr_seen <= hdr_seen + 1;
        beat_idx <= 0;
      end
      if (tx_valid && tx_ready) begin
        beat_idx   <= beat_idx + 1;
        beat_total <= beat_total + 1;
      end
    end
  end

  a_hdr: assert property (@(posedge clk) disable iff (rst)
      tx_hdr_valid && tx_hdr_ready |-> tx_hdr == exp_hdr)
    else begin
      $display("Test failures found");
      $fatal(1, "Error tx_hdr expected %h got %h", $sampled(exp_hdr), $sampled(tx_hdr));
    end

  a_beat: assert property (@(posedge clk) disable iff (rst)
      tx_valid && tx_ready |-> tx_beat == exp_beat)
    else begin
      $display("Test failures found");
      $fatal(1, "Error tx_beat expected %h got %h", $sampled(exp_beat), $sampled(tx_beat));
    end

  a_no_extra_hdr: assert property (@(posedge clk) disable iff (rst)
      tx_hdr_valid |-> hdr_sent > hdr_seen)
    else begin
      $display("Test failures found");
      $fatal(1, "a tx header was offered with no transfer pending");
    end

  a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
      tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
    else begin
      $display("Test failures found");
      $fatal(1, "tx header dropped or changed while stalled");
    end

  a_beat_hold: assert property (@(posedge clk) disable iff (rst)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else begin
      $display("Test failures found");
      $fatal(1, "tx beat dropped or changed while stalled");
    end

  a_busy_on: assert property (@(posedge clk) disable iff (rst)
      tx_hdr_valid || tx_valid |-> busy)
    else begin
      $display("Test failures found");
      $fatal(1, "busy low during a transfer");
    end

  a_busy_off: assert property (@(posedge clk) disable iff (rst)
      tx_valid && tx_ready && tx_beat.last |=> !busy)
    else begin
      $display("Test failures found");
      $fatal(1, "busy still high after the last beat");
    end

  a_drop: assert property (@(posedge clk) disable iff (rst)
      drop_expect |-> (!rx_hdr_valid || rx_hdr_ready) && (!rx_valid || rx_ready))
    else begin
      $display("Test failures found");
      $fatal(1, "a dropped frame was stalled on the receive side");
    end

  // random back-pressure on both tx channels.
  initial begin
    tx_ready     = 1'b0;
    tx_hdr_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      tx_ready     = ($urandom % 4) != 0;
      tx_hdr_ready = ($urandom % 3) == 0;
    end
  end

  // ready is sampled at the falling edge, where it is settled.
  task automatic wait_rx_accept(input bit on_beat);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = on_beat ? rx_ready : rx_hdr_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_frame(input udp_port_t port, input ip_addr_t src, input int nwords);
    rx_hdr.src_ip   = src;
    rx_hdr.dst_ip   = LOC_IP;
    rx_hdr.src_port = 16'hC000;
    rx_hdr.dst_port = port;
    rx_hdr.length   = udp_len_t'(8 + 8 * nwords);
    rx_hdr_valid    = 1'b1;
    wait_rx_accept(1'b0);
    rx_hdr_valid = 1'b0;
    for (int i = 0; i < nwords; i++) begin
      rx_beat.data = fw[i];
      rx_beat.keep = '1;
      rx_beat.last = (i == nwords - 1);
      rx_valid     = 1'b1;
      wait_rx_accept(1'b1);
    end
    rx_valid = 1'b0;
  endtask

  task automatic launch_transfer(input dma_len_t len, input int nwords);
    ip_addr_t src;
    qpn_t     qpn;
    psn_t     psn;
    rkey_t    rkey;
    vaddr_t   va;
    src  = $urandom;
    qpn  = qpn_t'($urandom);
    psn  = psn_t'($urandom);
    rkey = $urandom;
    va   = {$urandom, $urandom};
    fw[0] = {8'h00, qpn, len};
    fw[1] = {rkey, 8'h00, psn};
    fw[2] = va;
    fw[3] = {$urandom, $urandom};
    exp_hdr.src_ip   = LOC_IP;
    exp_hdr.dst_ip   = src; // reply to the requester.
    exp_hdr.src_port = `ROCE_UDP_PORT;
    exp_hdr.dst_port = `ROCE_UDP_PORT;
    exp_hdr.udp_len  = udp_len_t'(len + `ROCE_HDR_BYTES);
    exp_hdr.opcode   = `ROCE_OP_RDMA_WRITE_ONLY;
    exp_hdr.p_key    = `ROCE_P_KEY;
    exp_hdr.psn      = psn;
    exp_hdr.dest_qp  = qpn;
    exp_hdr.ack_req  = 1'b1;
    exp_hdr.vaddr    = va;
    exp_hdr.r_key    = rkey;
    exp_hdr.dma_len  = len;
    hdr_sent  = hdr_sent + 1;
    beats_exp = beats_exp + int'((len + 32'd7) / 32'd8);
    send_frame(`CM_LISTEN_PORT, src, nwords);
  endtask

  // control frame that must not start a transfer.
  task automatic send_ignored_control(input int nwords);
    for (int i = 0; i < nwords; i++) begin
      fw[i] = {$urandom, $urandom};
    end
    send_frame(`CM_LISTEN_PORT, $urandom, nwords);
  endtask

  task automatic send_drop(input udp_port_t port, input int nwords);
    for (int i = 0; i < nwords; i++) begin
      fw[i] = {$urandom, $urandom};
    end
    drop_expect = 1'b1;
    send_frame(port, $urandom, nwords);
    drop_expect = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy || hdr_seen != hdr_sent || beat_total != beats_exp) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(32'h3551));
    rst          = 1'b1;
    loc_ip_addr  = LOC_IP;
    rx_hdr       = '0;
    rx_hdr_valid = 1'b0;
    rx_beat      = '0;
    rx_valid     = 1'b0;
    drop_expect  = 1'b0;
    exp_hdr      = '0;
    hdr_sent     = 0;
    beats_exp    = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!tx_hdr_valid && !tx_valid && !busy && rx_hdr_ready) else begin
      $display("Test failures found");
      $fatal(1, "outputs not in their reset state after reset");
    end
    @(posedge clk);
    #1;
    launch_transfer(32'd8, 3);
    wait_idle();
    launch_transfer(32'd13, 3);
    wait_idle();
    launch_transfer(32'd100, 4); // extra word ignored.
    wait_idle();
    // second control frame lands while the long transfer runs.
    launch_transfer(32'd512, 3);
    while (hdr_seen != hdr_sent) @(negedge clk);
    @(posedge clk);
    #1;
    assert (busy) else begin
      $display("Test failures found");
      $fatal(1, "busy low while the long transfer streams");
    end
    send_ignored_control(3);
    wait_idle();
    repeat (4) begin
      launch_transfer(dma_len_t'($urandom % 512) + 32'd1, 3);
      wait_idle();
    end
    // side frames last, so a stray header meets no pending transfer.
    send_drop(`ROCE_UDP_PORT, 3);
    send_drop(16'h0035, 5);
    send_ignored_control(2); // too short to start.
    repeat (20) @(negedge clk);
    if (hdr_seen == hdr_sent && beat_total == beats_exp) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "Error hdr_seen expected %h got %h, beat_total expected %h got %h",
             hdr_sent, hdr_seen, beats_exp, beat_total);
    end
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/net_pkg.sv
rtl/roce_pkg.sv
rtl/udp_rx_steer.sv
rtl/conn_manager.sv
rtl/payload_gen.sv
rtl/roce_tx_framer.sv
rtl/roce_min_stack.sv
tests/tb_roce_min_stack.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f verilog.f \
  --top-module tb_roce_min_stack \
  -Mdir obj_dir -o tb_roce_min_stack

./obj_dir/tb_roce_min_stack
